// ==== tb.f ====
rtl/mem_bus_pkg.sv
rtl/fetch_pkg.sv
rtl/inst_fetch.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/sram_port.sv
rtl/fetch_mem_top.sv
tb/fetch_mem_checker.sv
tb/tb_fetch_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_mem
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+1000

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_fetch_mem.sv ====
`timescale 1ns/1ps

module tb_fetch_mem;
    import mem_bus_pkg::*;
    import fetch_pkg::*;

    localparam int        CLK_PERIOD      = 8;
    localparam int        RESET_CYCLES    = 10;
    localparam int        PROG_WORDS      = 128;
    // cycles per instruction with arbitration, redirects and held credits
    localparam int        FETCH_WORST_CYC = 10;
    localparam int        WATCHDOG_NS     = PROG_WORDS * 2 * FETCH_WORST_CYC * CLK_PERIOD;
    localparam bus_addr_t PROG_BASE       = RESET_PC;
    // word 200, outside the program
    localparam bus_addr_t MERGE_ADDR      = RESET_PC + 64'h640;

    logic        clk;
    logic        arst_n_i;
    logic        run_i;
    redirect_t   redirect_i;
    logic        redirect_valid_i;
    fetch_pkt_t  pkt_o;
    logic        inst_valid_o;
    logic        credit_i = 1'b0;
    mem_req_t    cmd_i;
    logic        cmd_valid_i;
    logic        cmd_ready_o;
    bus_data_t   load_data_o;
    logic        rsp_valid_o;

    logic [63:0] prog_rng;
    logic [63:0] credit_rng = 64'd86;
    logic        hold_credits;
    int          inst_seen = 0;
    int          rsp_seen = 0;
    int          credits_given = 0;
    int          cmds_sent;

    fetch_mem_top i_fetch_mem_top (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .run_i            (run_i),
        .redirect_i       (redirect_i),
        .redirect_valid_i (redirect_valid_i),
        .pkt_o            (pkt_o),
        .inst_valid_o     (inst_valid_o),
        .credit_i         (credit_i),
        .cmd_i            (cmd_i),
        .cmd_valid_i      (cmd_valid_i),
        .cmd_ready_o      (cmd_ready_o),
        .load_data_o      (load_data_o),
        .rsp_valid_o      (rsp_valid_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    always @(posedge clk) begin
        inst_seen <= inst_seen + int'(inst_valid_o);
        rsp_seen  <= rsp_seen + int'(rsp_valid_o);
    end

    // consumer frees delivered instructions on random cycles
    always @(negedge clk) begin
        credit_rng = xorshift(credit_rng);
        if (!hold_credits && inst_seen > credits_given && credit_rng[0]) begin
            credit_i = 1'b1;
            credits_given++;
        end else begin
            credit_i = 1'b0;
        end
    end

    // called on a falling edge, returns on the one after the accept
    task automatic send_cmd(input bus_addr_t addr, input logic we, input bus_strb_t strb,
                            input bus_data_t data);
        while (!cmd_ready_o) begin
            @(negedge clk);
        end
        cmd_i       = '{addr: addr, we: we, wstrb: strb, wdata: data};
        cmd_valid_i = 1'b1;
        @(negedge clk);
        cmd_valid_i = 1'b0;
        cmds_sent++;
    endtask

    task automatic wait_rsps();
        while (rsp_seen < cmds_sent) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_insts(input int n);
        int target;
        target = inst_seen + n;
        while (inst_seen < target) begin
            @(negedge clk);
        end
    endtask

    task automatic steer_fetch(input redirect_kind_e kind, input logic taken,
                               input pc_t base_pc, input logic [63:0] imm,
                               input logic [63:0] rs1, input pc_t mtvec);
        @(negedge clk);
        redirect_i = '{kind: kind, branch_taken: taken, base_pc: base_pc, imm: imm,
                       rs1_data: rs1, mtvec: mtvec};
        redirect_valid_i = 1'b1;
        @(negedge clk);
        redirect_valid_i = 1'b0;
        redirect_i       = '0;
    endtask

    task automatic load_program();
        for (int w = 0; w < PROG_WORDS; w++) begin
            prog_rng = xorshift(prog_rng);
            send_cmd(PROG_BASE + bus_addr_t'(w * 8), 1'b1, '1, prog_rng);
        end
    endtask

    task automatic report_counts();
        $display("errors=%0d instructions=%0d credits=%0d commands=%0d responses=%0d",
                 i_fetch_mem_top.i_fetch_mem_checker.err_cnt, inst_seen, credits_given,
                 cmds_sent, rsp_seen);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with stimulus still running", WATCHDOG_NS);
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        arst_n_i         = 1'b1;
        run_i            = 1'b0;
        redirect_i       = '0;
        redirect_valid_i = 1'b0;
        cmd_i            = '0;
        cmd_valid_i      = 1'b0;
        hold_credits     = 1'b0;
        prog_rng         = 64'd86;
        cmds_sent        = 0;
        #1;
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n_i = 1'b1;

        load_program();
        // byte merge on one word, then read it back
        prog_rng = xorshift(prog_rng);
        send_cmd(MERGE_ADDR, 1'b1, 8'hFF, prog_rng);
        prog_rng = xorshift(prog_rng);
        send_cmd(MERGE_ADDR, 1'b1, 8'h0F, prog_rng);
        prog_rng = xorshift(prog_rng);
        send_cmd(MERGE_ADDR, 1'b1, 8'hA5, prog_rng);
        send_cmd(MERGE_ADDR, 1'b0, 8'h00, '0);
        wait_rsps();

        run_i = 1'b1;
        wait_insts(24);
        // every field points somewhere else, so a wrong priority shows up
        steer_fetch(RD_JAL, 1'b0, 64'h8000_0010, 64'h80, 64'h8000_0300, 64'h8000_0340);
        wait_insts(16);
        steer_fetch(RD_BRANCH, 1'b1, 64'h8000_0100, 64'hFFFF_FFFF_FFFF_FFC0,
                    64'h8000_0301, 64'h8000_0340);
        wait_insts(16);
        steer_fetch(RD_BRANCH, 1'b0, 64'h8000_0000, 64'h10, 64'h8000_0300, 64'h8000_0340);
        wait_insts(16);
        steer_fetch(RD_JALR, 1'b0, 64'h8000_0300, 64'h21, 64'h8000_0020, 64'h8000_0340);
        wait_insts(16);
        steer_fetch(RD_TRAP, 1'b0, 64'h8000_0010, 64'h8, 64'h8000_0100, 64'h8000_0200);
        wait_insts(16);

        // starve the fetch unit of credits for a while
        @(posedge clk);
        hold_credits = 1'b1;
        repeat (40) @(posedge clk);
        hold_credits = 1'b0;
        @(negedge clk);
        wait_insts(16);

        steer_fetch(RD_TRAP, 1'b0, 64'h8000_0010, 64'h8, 64'h8000_0100, RESET_PC);
        for (int w = 0; w < 8; w++) begin
            send_cmd(PROG_BASE + bus_addr_t'(w * 24), 1'b0, '0, '0);
        end
        wait_rsps();
        wait_insts(8);

        run_i = 1'b0;
        repeat (8) @(negedge clk);
        report_counts();
        if (i_fetch_mem_top.i_fetch_mem_checker.err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/fetch_mem_checker.sv ====
`timescale 1ns/1ps

module fetch_mem_checker (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic                   run_i,
    input fetch_pkg::redirect_t   redirect_i,
    input logic                   redirect_valid_i,
    input fetch_pkg::fetch_pkt_t  pkt_o,
    input logic                   inst_valid_o,
    input logic                   credit_i,
    input mem_bus_pkg::mem_req_t  cmd_i,
    input logic                   cmd_valid_i,
    input logic                   cmd_ready_o,
    input mem_bus_pkg::bus_data_t load_data_o,
    input logic                   rsp_valid_o
);
    import mem_bus_pkg::*;
    import fetch_pkg::*;

    // longest gap between deliveries while the fetch unit holds a credit
    localparam int STALL_MAX = 24;

    bus_data_t            shadow [MEM_WORDS];
    bus_data_t            ld_exp [4];
    logic [1:0]           ld_wr_q;
    logic [1:0]           ld_rd_q;
    bus_data_t            ld_head;
    pc_t                  exp_pc_q;
    int                   owed_q;
    int                   stall_q;
    logic                 redirect_taken;
    pc_t                  redirect_target;
    logic                 cmd_acc;
    logic [MEM_IDX_W-1:0] cmd_idx;
    bus_data_t            fetch_word;
    inst_t                exp_inst;
    int                   fail_reset = 0;
    int                   fail_pc = 0;
    int                   fail_inst = 0;
    int                   fail_load = 0;
    int                   fail_credit = 0;
    int                   fail_stall = 0;
    int                   err_cnt;

    assign err_cnt = fail_reset + fail_pc + fail_inst + fail_load + fail_credit + fail_stall;

    function automatic bus_data_t merge_bytes(input bus_data_t old_word,
                                              input bus_data_t new_word,
                                              input bus_strb_t strb);
        bus_data_t mask;
        for (int b = 0; b < BUS_BYTES; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // where the next delivered pc must come from
    always_comb begin
        redirect_taken  = 1'b0;
        redirect_target = exp_pc_q;
        if (redirect_valid_i) begin
            case (redirect_i.kind)
                RD_JAL: begin
                    redirect_taken  = 1'b1;
                    redirect_target = redirect_i.base_pc + redirect_i.imm;
                end
                RD_BRANCH: begin
                    redirect_taken  = redirect_i.branch_taken;
                    redirect_target = redirect_i.base_pc + redirect_i.imm;
                end
                RD_JALR: begin
                    redirect_taken  = 1'b1;
                    redirect_target = (redirect_i.rs1_data + redirect_i.imm) & ~64'd1;
                end
                RD_TRAP: begin
                    redirect_taken  = 1'b1;
                    redirect_target = redirect_i.mtvec;
                end
                default: ;
            endcase
        end
    end

    assign cmd_acc    = cmd_valid_i && cmd_ready_o;
    assign cmd_idx    = cmd_i.addr[WORD_OFS_W +: MEM_IDX_W];
    assign fetch_word = shadow[exp_pc_q[WORD_OFS_W +: MEM_IDX_W]];
    assign exp_inst   = exp_pc_q[2] ? fetch_word[63:32] : fetch_word[31:0];
    assign ld_head    = ld_exp[ld_rd_q];

    // stores answer with zero data
    always_ff @(posedge clk) begin
        if (cmd_acc && cmd_i.we) begin
            shadow[cmd_idx] <= merge_bytes(shadow[cmd_idx], cmd_i.wdata, cmd_i.wstrb);
        end
        if (cmd_acc) begin
            ld_exp[ld_wr_q] <= cmd_i.we ? '0 : shadow[cmd_idx];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_pc_q <= RESET_PC;
            owed_q   <= 0;
            stall_q  <= 0;
            ld_wr_q  <= '0;
            ld_rd_q  <= '0;
        end else begin
            if (redirect_taken) begin
                exp_pc_q <= redirect_target;
            end else if (inst_valid_o) begin
                exp_pc_q <= exp_pc_q + 64'd4;
            end
            owed_q <= owed_q + int'(inst_valid_o) - int'(credit_i);
            if (!run_i || inst_valid_o || owed_q >= FETCH_CREDITS) begin
                stall_q <= 0;
            end else begin
                stall_q <= stall_q + 1;
            end
            if (cmd_acc) begin
                ld_wr_q <= ld_wr_q + 2'd1;
            end
            if (rsp_valid_o) begin
                ld_rd_q <= ld_rd_q + 2'd1;
            end
        end
    end

    a_reset_outputs: assert property (@(posedge clk)
        !arst_n_i |-> !inst_valid_o && !rsp_valid_o && cmd_ready_o)
        else begin
            fail_reset++;
            $error("FAIL reset inst_valid_o=%h rsp_valid_o=%h cmd_ready_o=%h",
                   $sampled(inst_valid_o), $sampled(rsp_valid_o), $sampled(cmd_ready_o));
        end

    a_fetch_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_valid_o |-> pkt_o.pc == exp_pc_q)
        else begin
            fail_pc++;
            $error("FAIL pkt_o.pc got %h expected %h", $sampled(pkt_o.pc), $sampled(exp_pc_q));
        end

    a_fetch_inst: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_valid_o |-> pkt_o.inst == exp_inst)
        else begin
            fail_inst++;
            $error("FAIL pkt_o.inst got %h expected %h", $sampled(pkt_o.inst),
                   $sampled(exp_inst));
        end

    a_load_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o |-> load_data_o == ld_head)
        else begin
            fail_load++;
            $error("FAIL load_data_o got %h expected %h", $sampled(load_data_o),
                   $sampled(ld_head));
        end

    a_credit_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
        owed_q <= FETCH_CREDITS)
        else begin
            fail_credit++;
            $error("FAIL uncredited instructions got %h limit %h", $sampled(owed_q),
                   FETCH_CREDITS);
        end

    a_fetch_resumes: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_q < STALL_MAX)
        else begin
            fail_stall++;
            $error("fetch made no progress although the fetch unit held a credit");
        end

endmodule

bind fetch_mem_top fetch_mem_checker i_fetch_mem_checker (.*);

// ==== rtl/fetch_mem_top.sv ====
`timescale 1ns/1ps

module fetch_mem_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   run_i,
    input  fetch_pkg::redirect_t   redirect_i,
    input  logic                   redirect_valid_i,
    output fetch_pkg::fetch_pkt_t  pkt_o,
    output logic                   inst_valid_o,
    input  logic                   credit_i,
    input  mem_bus_pkg::mem_req_t  cmd_i,
    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,
    output mem_bus_pkg::bus_data_t load_data_o,
    output logic                   rsp_valid_o
);
    import mem_bus_pkg::*;

    mem_req_t if_req;
    logic     if_req_valid;
    logic     if_req_accept;
    mem_rsp_t if_rsp;
    logic     if_rsp_valid;
    mem_req_t ls_req;
    logic     ls_req_valid;
    logic     ls_req_accept;
    mem_rsp_t ls_rsp;
    logic     ls_rsp_valid;
    mem_req_t mem_req;
    logic     mem_req_valid;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;
    logic     mem_credit;

    inst_fetch i_inst_fetch (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .run_i            (run_i),
        .redirect_i       (redirect_i),
        .redirect_valid_i (redirect_valid_i),
        .req_o            (if_req),
        .req_valid_o      (if_req_valid),
        .req_accept_i     (if_req_accept),
        .rsp_i            (if_rsp),
        .rsp_valid_i      (if_rsp_valid),
        .pkt_o            (pkt_o),
        .inst_valid_o     (inst_valid_o),
        .credit_i         (credit_i)
    );

    load_store_unit i_load_store_unit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .req_o        (ls_req),
        .req_valid_o  (ls_req_valid),
        .req_accept_i (ls_req_accept),
        .rsp_i        (ls_rsp),
        .rsp_valid_i  (ls_rsp_valid),
        .load_data_o  (load_data_o),
        .rsp_valid_o  (rsp_valid_o)
    );

    mem_arbiter i_mem_arbiter (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .if_req_i        (if_req),
        .if_req_valid_i  (if_req_valid),
        .if_req_accept_o (if_req_accept),
        .if_rsp_o        (if_rsp),
        .if_rsp_valid_o  (if_rsp_valid),
        .ls_req_i        (ls_req),
        .ls_req_valid_i  (ls_req_valid),
        .ls_req_accept_o (ls_req_accept),
        .ls_rsp_o        (ls_rsp),
        .ls_rsp_valid_o  (ls_rsp_valid),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_rsp_i       (mem_rsp),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_credit_i    (mem_credit)
    );

    sram_port i_sram_port (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (mem_req),
        .req_valid_i (mem_req_valid),
        .rsp_o       (mem_rsp),
        .rsp_valid_o (mem_rsp_valid),
        .credit_o    (mem_credit)
    );

endmodule

// ==== rtl/sram_port.sv ====
`timescale 1ns/1ps

module sram_port (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  mem_bus_pkg::mem_req_t req_i,
    input  logic                  req_valid_i,
    output mem_bus_pkg::mem_rsp_t rsp_o,
    output logic                  rsp_valid_o,
    output logic                  credit_o
);
    import mem_bus_pkg::*;

    bus_data_t             mem_q [MEM_WORDS];
    logic [MEM_IDX_W-1:0]  idx;
    logic                  s1_valid_q;
    bus_data_t             s1_data_q;
    logic                  s2_valid_q;
    bus_data_t             s2_data_q;

    // upper address bits wrap around the array
    assign idx = req_i.addr[WORD_OFS_W +: MEM_IDX_W];

    assign rsp_o       = '{rdata: s2_data_q};
    assign rsp_valid_o = s2_valid_q;
    // one credit back per retired request
    assign credit_o    = s2_valid_q;

    always_ff @(posedge clk) begin
        if (req_valid_i && req_i.we) begin
            for (int b = 0; b < BUS_BYTES; b++) begin
                if (req_i.wstrb[b]) begin
                    mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
        if (req_valid_i) begin
            s1_data_q <= req_i.we ? '0 : mem_q[idx];
        end
        s2_data_q <= s1_data_q;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  mem_bus_pkg::mem_req_t if_req_i,
    input  logic                  if_req_valid_i,
    output logic                  if_req_accept_o,
    output mem_bus_pkg::mem_rsp_t if_rsp_o,
    output logic                  if_rsp_valid_o,
    input  mem_bus_pkg::mem_req_t ls_req_i,
    input  logic                  ls_req_valid_i,
    output logic                  ls_req_accept_o,
    output mem_bus_pkg::mem_rsp_t ls_rsp_o,
    output logic                  ls_rsp_valid_o,
    output mem_bus_pkg::mem_req_t mem_req_o,
    output logic                  mem_req_valid_o,
    input  mem_bus_pkg::mem_rsp_t mem_rsp_i,
    input  logic                  mem_rsp_valid_i,
    input  logic                  mem_credit_i
);
    import mem_bus_pkg::*;

    logic [MEM_CREDIT_W-1:0] mem_cnt_q;
    master_id_t              prio_q;
    master_id_t              route_q [MEM_CREDITS];
    logic [ROUTE_PTR_W-1:0]  route_wr_q;
    logic [ROUTE_PTR_W-1:0]  route_rd_q;
    logic                    can_grant;
    logic                    grant_if;
    logic                    grant_ls;
    logic                    grant;
    master_id_t              grant_id;
    master_id_t              head_id;

    assign can_grant = mem_cnt_q != '0;
    assign grant_if  = can_grant && if_req_valid_i && (!ls_req_valid_i || prio_q == MID_FETCH);
    assign grant_ls  = can_grant && ls_req_valid_i && (!if_req_valid_i || prio_q == MID_LS);
    assign grant     = grant_if || grant_ls;
    assign grant_id  = grant_ls ? MID_LS : MID_FETCH;

    assign if_req_accept_o = grant_if;
    assign ls_req_accept_o = grant_ls;
    assign mem_req_o       = grant_ls ? ls_req_i : if_req_i;
    assign mem_req_valid_o = grant;

    // responses come back in grant order
    assign head_id        = route_q[route_rd_q];
    assign if_rsp_o       = mem_rsp_i;
    assign ls_rsp_o       = mem_rsp_i;
    assign if_rsp_valid_o = mem_rsp_valid_i && (head_id == MID_FETCH);
    assign ls_rsp_valid_o = mem_rsp_valid_i && (head_id == MID_LS);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_cnt_q  <= MEM_CREDIT_W'(MEM_CREDITS);
            prio_q     <= MID_FETCH;
            route_wr_q <= '0;
            route_rd_q <= '0;
        end else begin
            mem_cnt_q <= mem_cnt_q - MEM_CREDIT_W'(grant) + MEM_CREDIT_W'(mem_credit_i);
            // the loser of this grant goes first next time
            if (grant_if) begin
                prio_q <= MID_LS;
            end else if (grant_ls) begin
                prio_q <= MID_FETCH;
            end
            if (grant) begin
                route_wr_q <= route_wr_q + 1'b1;
            end
            if (mem_rsp_valid_i) begin
                route_rd_q <= route_rd_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            route_q[route_wr_q] <= grant_id;
        end
    end

endmodule

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mem_bus_pkg::mem_req_t  cmd_i,
    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,
    output mem_bus_pkg::mem_req_t  req_o,
    output logic                   req_valid_o,
    input  logic                   req_accept_i,
    input  mem_bus_pkg::mem_rsp_t  rsp_i,
    input  logic                   rsp_valid_i,
    output mem_bus_pkg::bus_data_t load_data_o,
    output logic                   rsp_valid_o
);
    import mem_bus_pkg::*;

    mem_req_t            q_q [LS_SLOTS];
    logic                q_wr_q;
    logic                q_rd_q;
    logic [LS_CNT_W-1:0] q_cnt_q;
    logic [LS_CNT_W-1:0] out_cnt_q;
    logic                cmd_acc;
    logic                pop;

    // outstanding covers queued and in-flight commands
    assign cmd_ready_o = out_cnt_q < LS_CNT_W'(LS_SLOTS);
    assign cmd_acc     = cmd_valid_i && cmd_ready_o;

    assign req_valid_o = q_cnt_q != '0;
    assign req_o       = q_q[q_rd_q];
    assign pop         = req_valid_o && req_accept_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_wr_q      <= 1'b0;
            q_rd_q      <= 1'b0;
            q_cnt_q     <= '0;
            out_cnt_q   <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            if (cmd_acc) begin
                q_wr_q <= ~q_wr_q;
            end
            if (pop) begin
                q_rd_q <= ~q_rd_q;
            end
            q_cnt_q     <= q_cnt_q + LS_CNT_W'(cmd_acc) - LS_CNT_W'(pop);
            out_cnt_q   <= out_cnt_q + LS_CNT_W'(cmd_acc) - LS_CNT_W'(rsp_valid_i);
            rsp_valid_o <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            q_q[q_wr_q] <= cmd_i;
        end
        if (rsp_valid_i) begin
            load_data_o <= rsp_i.rdata;
        end
    end

endmodule

// ==== rtl/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  run_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  redirect_valid_i,
    output mem_bus_pkg::mem_req_t req_o,
    output logic                  req_valid_o,
    input  logic                  req_accept_i,
    input  mem_bus_pkg::mem_rsp_t rsp_i,
    input  logic                  rsp_valid_i,
    output fetch_pkg::fetch_pkt_t pkt_o,
    output logic                  inst_valid_o,
    input  logic                  credit_i
);
    import fetch_pkg::*;

    pc_t                     pc_q;
    epoch_t                  epoch_q;
    fetch_tag_t              req_q;
    logic                    req_valid_q;
    logic [FETCH_CRED_W-1:0] cred_q;
    fetch_tag_t              tag_q [FETCH_CREDITS];
    logic [FETCH_PTR_W-1:0]  tag_wr_q;
    logic [FETCH_PTR_W-1:0]  tag_rd_q;
    logic                    redirect_take;
    pc_t                     redirect_pc;
    pc_t                     jalr_sum;
    pc_t                     issue_pc;
    epoch_t                  issue_epoch;
    logic                    issue;
    fetch_tag_t              head;
    logic                    keep;
    logic                    drop;
    inst_t                   inst;

    // redirect target, jal and taken branch first, then jalr, then trap
    always_comb begin
        jalr_sum      = redirect_i.rs1_data + redirect_i.imm;
        redirect_take = 1'b0;
        redirect_pc   = pc_q;
        if (redirect_valid_i) begin
            if (redirect_i.kind == RD_JAL ||
                (redirect_i.kind == RD_BRANCH && redirect_i.branch_taken)) begin
                redirect_take = 1'b1;
                redirect_pc   = redirect_i.base_pc + redirect_i.imm;
            end else if (redirect_i.kind == RD_JALR) begin
                redirect_take = 1'b1;
                redirect_pc   = {jalr_sum[63:1], 1'b0};
            end else if (redirect_i.kind == RD_TRAP) begin
                redirect_take = 1'b1;
                redirect_pc   = redirect_i.mtvec;
            end
        end
    end

    // a taken redirect issues straight to the target in the same cycle
    assign issue_pc    = redirect_take ? redirect_pc : pc_q;
    assign issue_epoch = redirect_take ? epoch_q + 1'b1 : epoch_q;
    assign issue       = run_i && (cred_q != '0) && (!req_valid_q || req_accept_i);

    assign head = tag_q[tag_rd_q];
    // a response landing with a redirect is already stale
    assign keep = rsp_valid_i && (head.epoch == epoch_q) && !redirect_take;
    assign drop = rsp_valid_i && !keep;
    assign inst = head.pc[2] ? rsp_i.rdata[63:32] : rsp_i.rdata[31:0];

    assign req_o       = '{addr: req_q.pc, we: 1'b0, wstrb: '0, wdata: '0};
    assign req_valid_o = req_valid_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q         <= RESET_PC;
            epoch_q      <= '0;
            req_valid_q  <= 1'b0;
            cred_q       <= FETCH_CRED_W'(FETCH_CREDITS);
            tag_wr_q     <= '0;
            tag_rd_q     <= '0;
            inst_valid_o <= 1'b0;
        end else begin
            epoch_q <= issue_epoch;
            if (issue) begin
                req_valid_q <= 1'b1;
                pc_q        <= issue_pc + 64'd4;
            end else begin
                if (req_accept_i) begin
                    req_valid_q <= 1'b0;
                end
                pc_q <= issue_pc;
            end
            // dropped responses hand their credit back here
            cred_q <= cred_q - FETCH_CRED_W'(issue) + FETCH_CRED_W'(credit_i)
                      + FETCH_CRED_W'(drop);
            if (req_valid_q && req_accept_i) begin
                tag_wr_q <= tag_wr_q + 1'b1;
            end
            if (rsp_valid_i) begin
                tag_rd_q <= tag_rd_q + 1'b1;
            end
            inst_valid_o <= keep;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_q <= '{pc: issue_pc, epoch: issue_epoch};
        end
        if (req_valid_q && req_accept_i) begin
            tag_q[tag_wr_q] <= req_q;
        end
        if (keep) begin
            pkt_o <= '{pc: head.pc, inst: inst};
        end
    end

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    localparam int FETCH_CREDITS = 4;
    localparam int FETCH_CRED_W  = $clog2(FETCH_CREDITS + 1);
    localparam int FETCH_PTR_W   = $clog2(FETCH_CREDITS);

    typedef logic [63:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [2:0]  epoch_t;

    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;

    typedef enum logic [2:0] {
        RD_NONE,
        RD_JAL,
        RD_BRANCH,
        RD_JALR,
        RD_TRAP
    } redirect_kind_e;

    typedef struct packed {
        redirect_kind_e kind;
        logic           branch_taken;
        pc_t            base_pc;
        logic [63:0]    imm;
        logic [63:0]    rs1_data;
        pc_t            mtvec;
    } redirect_t;

    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } fetch_pkt_t;

    // pc and epoch of one issued fetch
    typedef struct packed {
        pc_t    pc;
        epoch_t epoch;
    } fetch_tag_t;

endpackage

// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // memory geometry
    localparam int MEM_WORDS   = 1024;
    localparam int BUS_BYTES   = 8;
    localparam int WORD_OFS_W  = $clog2(BUS_BYTES);
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);

    // requests the memory side can hold at once
    localparam int MEM_CREDITS  = 4;
    localparam int MEM_CREDIT_W = $clog2(MEM_CREDITS + 1);
    localparam int ROUTE_PTR_W  = $clog2(MEM_CREDITS);

    // load/store command slots
    localparam int LS_SLOTS = 2;
    localparam int LS_CNT_W = $clog2(LS_SLOTS + 1);

    typedef logic [63:0]          bus_addr_t;
    typedef logic [63:0]          bus_data_t;
    typedef logic [BUS_BYTES-1:0] bus_strb_t;
    typedef logic [0:0]           master_id_t;

    localparam master_id_t MID_FETCH = 1'b0;
    localparam master_id_t MID_LS    = 1'b1;

    typedef struct packed {
        bus_addr_t addr;
        logic      we;
        bus_strb_t wstrb;
        bus_data_t wdata;
    } mem_req_t;

    // stores answer too, with zero data
    typedef struct packed {
        bus_data_t rdata;
    } mem_rsp_t;

endpackage
